// File: filelist.f
+incdir+source
source/cache_geom_pkg.sv
source/ctrl_state_pkg.sv
source/line_fill_sequencer.sv
source/lease_table_loader.sv
source/mem_port_arbiter.sv
source/lease_cache_controller.sv
tb/lease_cache_properties.sv
tb/tb_lease_cache.sv

// File: source/cache_geom_pkg.sv
`include "lease_cache_defs.svh"

package cache_geom_pkg;

	typedef logic [`BW_WORD_ADDR-1:0]           word_addr_t;
	typedef logic [`BW_WORD_ADDR-`BW_BLOCK-1:0] tag_t;
	typedef logic [$clog2(`CACHE_LINES)-1:0]    line_t;

	// {line, word} into cache memory
	typedef logic [$clog2(`CACHE_LINES)+`BW_BLOCK-1:0] cache_addr_t;

	// lease table counter
	// flat view counts and offsets the memory address,
	// field view splits table select from entry index
	typedef union packed {
		logic [$clog2(`LLT_ENTRIES)+1:0] flat;
		struct packed {
			logic [1:0]                      table_sel;  // addr, lease0, lease1, prob
			logic [$clog2(`LLT_ENTRIES)-1:0] entry;
		} field;
	} llt_index_u;

endpackage

// File: source/ctrl_state_pkg.sv
package ctrl_state_pkg;

	// line fill sequencer
	typedef enum logic [2:0] {
		FILL_NORMAL       = 3'd0,  // hit/miss check
		FILL_WAIT_READY   = 3'd1,  // swap answer, then block or word request
		FILL_WAIT_VICTIM  = 3'd2,  // wait for replacement line
		FILL_WRITE_BUFFER = 3'd3,  // dirty victim out
		FILL_READ_BUFFER  = 3'd4,  // new block in
		FILL_NO_SWAP_READ = 3'd5   // bypass load word
	} fill_state_e;

	// lease table loader
	typedef enum logic [1:0] {
		LOAD_IDLE    = 2'd0,
		LOAD_REQUEST = 2'd1,
		LOAD_SERVICE = 2'd2
	} load_state_e;

endpackage

// File: source/lease_cache_controller.sv
`include "lease_cache_defs.svh"

module lease_cache_controller (
	input  logic                                          clock_i,
	input  logic                                          resetn_i,
	input  logic                                          enable_i,
	input  logic [31:0]                                   phase_i,
	// core
	input  logic                                          core_req_i,
	input  logic                                          core_rw_i,
	input  cache_geom_pkg::tag_t                          core_tag_i,
	input  logic [`BW_BLOCK-1:0]                          core_word_i,
	input  logic [31:0]                                   core_data_i,
	output logic                                          core_done_o,
	output logic                                          core_hit_o,
	output logic [31:0]                                   core_data_o,
	// tag memory
	input  logic                                          cam_hit_i,
	input  cache_geom_pkg::tag_t                          cam_tag_i,
	input  cache_geom_pkg::line_t                         cam_addr_i,
	output logic                                          cam_wren_o,
	output cache_geom_pkg::line_t                         cam_addr_o,
	// cache memory
	input  logic [31:0]                                   cache_mem_data_i,
	output cache_geom_pkg::cache_addr_t                   cache_mem_add_o,
	output logic                                          cache_mem_rw_o,
	output logic [31:0]                                   cache_mem_data_o,
	// buffer
	input  logic                                          buffer_read_ready_i,
	input  logic [31:0]                                   buffer_data_i,
	output logic                                          buffer_read_ack_o,
	input  logic                                          buffer_write_ready_i,
	output logic [31:0]                                   buffer_data_o,
	output logic                                          buffer_write_ack_o,
	// memory command
	input  logic                                          mem_ready_i,
	output logic                                          mem_req_o,
	output logic                                          mem_req_block_o,
	output logic                                          mem_rw_o,
	output cache_geom_pkg::word_addr_t                    mem_addr_o,
	// lease policy
	input  logic                                          repl_done_i,
	input  cache_geom_pkg::line_t                         repl_addr_i,
	input  logic                                          repl_swap_i,
	output logic                                          policy_hit_o,
	output logic                                          policy_miss_o,
	// lease table
	output logic                                          llt_wren_o,
	output logic [$bits(cache_geom_pkg::llt_index_u)-1:0] llt_addr_o,
	output logic [31:0]                                   llt_data_o,
	// performance
	output logic                                          flag_writeback_o,
	output logic                                          flag_swap_o
);

	logic                       load_grant;
	logic                       load_req;
	logic                       seq_idle;
	logic                       seq_core_done;
	logic                       seq_mem_req;
	logic                       seq_mem_req_block;
	logic                       seq_mem_rw;
	cache_geom_pkg::word_addr_t seq_mem_addr;
	logic                       seq_rd_ack;
	logic                       ld_mem_req;
	cache_geom_pkg::word_addr_t ld_mem_addr;
	logic                       ld_rd_ack;

	line_fill_sequencer seq0 (
		.load_grant_i      (load_grant),
		.seq_idle_o        (seq_idle),
		.core_done_o       (seq_core_done),
		.buffer_read_ack_o (seq_rd_ack),
		.mem_req_o         (seq_mem_req),
		.mem_req_block_o   (seq_mem_req_block),
		.mem_rw_o          (seq_mem_rw),
		.mem_addr_o        (seq_mem_addr),
		.*
	);

	lease_table_loader loader0 (
		.load_grant_i      (load_grant),
		.load_req_o        (load_req),
		.mem_req_o         (ld_mem_req),
		.mem_addr_o        (ld_mem_addr),
		.buffer_read_ack_o (ld_rd_ack),
		.*
	);

	mem_port_arbiter arb0 (
		.load_req_i            (load_req),
		.seq_idle_i            (seq_idle),
		.seq_mem_req_i         (seq_mem_req),
		.seq_mem_req_block_i   (seq_mem_req_block),
		.seq_mem_rw_i          (seq_mem_rw),
		.seq_mem_addr_i        (seq_mem_addr),
		.seq_buffer_read_ack_i (seq_rd_ack),
		.seq_core_done_i       (seq_core_done),
		.ld_mem_req_i          (ld_mem_req),
		.ld_mem_addr_i         (ld_mem_addr),
		.ld_buffer_read_ack_i  (ld_rd_ack),
		.load_grant_o          (load_grant),
		.*
	);

endmodule

// File: source/lease_cache_defs.svh
`ifndef LEASE_CACHE_DEFS_SVH
`define LEASE_CACHE_DEFS_SVH

// ------------------------------------------------------------------------
// address geometry
// ------------------------------------------------------------------------
`define BW_WORD_ADDR    24          // word addressed memory
`define BW_BLOCK        4           // 16 words per block
`define CACHE_LINES     16

// ------------------------------------------------------------------------
// lease lookup table
// ------------------------------------------------------------------------
// four tables of LLT_ENTRIES each, one block per phase section
`define LLT_ENTRIES     4
`define LEASE_BASE_ADDR 24'h7F0000  // phase 0 section
`define PHASE_SHIFT     4           // log2 entries + 2 table select bits

`endif

// File: source/lease_table_loader.sv
`include "lease_cache_defs.svh"

module lease_table_loader (
	input  logic                                          clock_i,
	input  logic                                          resetn_i,
	input  logic                                          enable_i,
	input  logic                                          load_grant_i,
	input  logic [31:0]                                   phase_i,
	input  logic                                          mem_ready_i,
	input  logic                                          buffer_read_ready_i,
	input  logic [31:0]                                   buffer_data_i,
	output logic                                          load_req_o,
	output logic                                          mem_req_o,
	output cache_geom_pkg::word_addr_t                    mem_addr_o,
	output logic                                          buffer_read_ack_o,
	output logic                                          llt_wren_o,
	output logic [$bits(cache_geom_pkg::llt_index_u)-1:0] llt_addr_o,
	output logic [31:0]                                   llt_data_o
);

	ctrl_state_pkg::load_state_e state;
	cache_geom_pkg::llt_index_u  cnt;           // table select and entry
	logic [7:0]                  phase_reg;     // phase of the loaded table
	logic                        phase_change;
	cache_geom_pkg::word_addr_t  section_addr;

	// bit 31 marks a valid phase number in the low byte
	assign phase_change = phase_i[31] && (phase_i[7:0] != phase_reg);

	assign section_addr = `LEASE_BASE_ADDR
		+ (cache_geom_pkg::word_addr_t'(phase_i[7:0]) << `PHASE_SHIFT);

	always_ff @(posedge clock_i) begin
		mem_req_o         <= 1'b0;
		buffer_read_ack_o <= 1'b0;
		llt_wren_o        <= 1'b0;

		if (!resetn_i) begin
			state      <= ctrl_state_pkg::LOAD_IDLE;
			load_req_o <= 1'b0;
			phase_reg  <= 8'hFF;  // no phase loaded
			cnt.flat   <= '0;
		end else if (enable_i) begin
			case (state)
			ctrl_state_pkg::LOAD_IDLE: begin
				if (phase_change) begin
					load_req_o <= 1'b1;  // held until the last word is written
					cnt.flat   <= '0;
					state      <= ctrl_state_pkg::LOAD_REQUEST;
				end
			end
			ctrl_state_pkg::LOAD_REQUEST: begin
				if (load_grant_i && mem_ready_i) begin
					mem_req_o  <= 1'b1;  // always a block read
					mem_addr_o <= section_addr + cache_geom_pkg::word_addr_t'(cnt.flat);
					state      <= ctrl_state_pkg::LOAD_SERVICE;
				end
			end
			ctrl_state_pkg::LOAD_SERVICE: begin
				if (buffer_read_ready_i) begin
					buffer_read_ack_o <= 1'b1;
					llt_wren_o        <= 1'b1;
					llt_addr_o        <= {cnt.field.table_sel, cnt.field.entry};
					llt_data_o        <= buffer_data_i;
					if (&cnt.flat) begin
						load_req_o <= 1'b0;
						phase_reg  <= phase_i[7:0];
						state      <= ctrl_state_pkg::LOAD_IDLE;
					end else begin
						cnt.flat <= cnt.flat + 1'b1;
					end
				end
			end
			default: state <= ctrl_state_pkg::LOAD_IDLE;
			endcase
		end
	end

endmodule

// File: source/line_fill_sequencer.sv
`include "lease_cache_defs.svh"

module line_fill_sequencer (
	input  logic                        clock_i,
	input  logic                        resetn_i,
	input  logic                        enable_i,
	input  logic                        load_grant_i,
	input  logic                        core_req_i,
	input  logic                        core_rw_i,
	input  cache_geom_pkg::tag_t        core_tag_i,
	input  logic [`BW_BLOCK-1:0]        core_word_i,
	input  logic [31:0]                 core_data_i,
	input  logic                        cam_hit_i,
	input  cache_geom_pkg::tag_t        cam_tag_i,
	input  cache_geom_pkg::line_t       cam_addr_i,
	input  logic [31:0]                 cache_mem_data_i,
	input  logic                        buffer_read_ready_i,
	input  logic [31:0]                 buffer_data_i,
	input  logic                        buffer_write_ready_i,
	input  logic                        mem_ready_i,
	input  logic                        repl_done_i,
	input  cache_geom_pkg::line_t       repl_addr_i,
	input  logic                        repl_swap_i,
	output logic                        seq_idle_o,
	output logic                        core_done_o,
	output logic                        core_hit_o,
	output logic [31:0]                 core_data_o,
	output logic                        cam_wren_o,
	output cache_geom_pkg::line_t       cam_addr_o,
	output cache_geom_pkg::cache_addr_t cache_mem_add_o,
	output logic                        cache_mem_rw_o,
	output logic [31:0]                 cache_mem_data_o,
	output logic                        buffer_read_ack_o,
	output logic                        buffer_write_ack_o,
	output logic [31:0]                 buffer_data_o,
	output logic                        mem_req_o,
	output logic                        mem_req_block_o,
	output logic                        mem_rw_o,
	output cache_geom_pkg::word_addr_t  mem_addr_o,
	output logic                        policy_hit_o,
	output logic                        policy_miss_o,
	output logic                        flag_writeback_o,
	output logic                        flag_swap_o
);

	ctrl_state_pkg::fill_state_e state;

	logic [`BW_BLOCK-1:0]       n_xfer;      // words moved in this block
	logic [`BW_BLOCK-1:0]       n_next;
	logic [`CACHE_LINES-1:0]    dirty;       // set by stores
	logic                       req_flag;    // core request still owed
	logic                       rw_flag;
	logic                       latch_swap;  // policy answer valid this cycle
	logic                       swap_reg;
	logic                       wb_pending;  // block write not yet issued
	cache_geom_pkg::line_t      victim;
	cache_geom_pkg::word_addr_t wb_addr;
	logic                       req_rw;
	logic                       swap_now;
	logic                       last_word;

	assign req_rw    = req_flag ? rw_flag : core_rw_i;
	assign swap_now  = latch_swap ? repl_swap_i : swap_reg;
	assign n_next    = n_xfer + 1'b1;
	assign last_word = &n_xfer;

	assign core_hit_o  = (core_req_i | req_flag) ? cam_hit_i : 1'b1;  // no stall when idle
	assign flag_swap_o = swap_reg;

	// free for a table load, nothing owed and nothing to write back
	assign seq_idle_o = (state == ctrl_state_pkg::FILL_NORMAL) && !req_flag
		&& !core_req_i && !wb_pending;

	always_ff @(posedge clock_i) begin
		// strobes are single cycle
		core_done_o        <= 1'b0;
		cam_wren_o         <= 1'b0;
		cache_mem_rw_o     <= 1'b0;
		buffer_read_ack_o  <= 1'b0;
		buffer_write_ack_o <= 1'b0;
		mem_req_o          <= 1'b0;
		mem_req_block_o    <= 1'b0;
		mem_rw_o           <= 1'b0;
		policy_hit_o       <= 1'b0;
		policy_miss_o      <= 1'b0;
		flag_writeback_o   <= 1'b0;

		if (!resetn_i) begin
			state      <= ctrl_state_pkg::FILL_NORMAL;
			n_xfer     <= '0;
			dirty      <= '0;
			req_flag   <= 1'b0;
			rw_flag    <= 1'b0;
			latch_swap <= 1'b0;
			swap_reg   <= 1'b0;
			wb_pending <= 1'b0;
		end else if (enable_i) begin
			case (state)
			// ----------------------------------------------------------------
			ctrl_state_pkg::FILL_NORMAL: begin
				if (load_grant_i) begin
					if (core_req_i) begin  // served once the table is in
						req_flag <= 1'b1;
						rw_flag  <= core_rw_i;
					end
				end else if (core_req_i || req_flag) begin
					if (cam_hit_i) begin
						cache_mem_rw_o   <= req_rw;
						cache_mem_add_o  <= {cam_addr_i, core_word_i};
						cache_mem_data_o <= core_data_i;  // don't care on a load
						core_done_o      <= 1'b1;
						policy_hit_o     <= 1'b1;
						swap_reg         <= 1'b1;         // line is cached
						req_flag         <= 1'b0;
						if (req_rw)
							dirty[cam_addr_i] <= 1'b1;
					end else begin
						// miss, policy answers swap next cycle
						policy_miss_o <= 1'b1;
						req_flag      <= 1'b1;
						rw_flag       <= req_rw;
						latch_swap    <= 1'b1;
						state         <= ctrl_state_pkg::FILL_WAIT_READY;
					end
				end
			end
			ctrl_state_pkg::FILL_WAIT_READY: begin
				latch_swap <= 1'b0;
				swap_reg   <= swap_now;
				if (mem_ready_i && !wb_pending) begin
					if (swap_now) begin
						mem_req_o       <= 1'b1;
						mem_req_block_o <= 1'b1;
						mem_addr_o      <= {core_tag_i, {`BW_BLOCK{1'b0}}};
						state           <= ctrl_state_pkg::FILL_WAIT_VICTIM;
					end else if (!rw_flag) begin
						// bypass load, single word
						req_flag   <= 1'b0;
						mem_req_o  <= 1'b1;
						mem_addr_o <= {core_tag_i, core_word_i};
						state      <= ctrl_state_pkg::FILL_NO_SWAP_READ;
					end else if (buffer_write_ready_i) begin
						// bypass store, word and command together
						req_flag           <= 1'b0;
						mem_req_o          <= 1'b1;
						mem_rw_o           <= 1'b1;
						mem_addr_o         <= {core_tag_i, core_word_i};
						buffer_write_ack_o <= 1'b1;
						buffer_data_o      <= core_data_i;
						core_done_o        <= 1'b1;
						state              <= ctrl_state_pkg::FILL_NORMAL;
					end
				end
			end
			ctrl_state_pkg::FILL_WAIT_VICTIM: begin
				if (repl_done_i) begin
					victim <= repl_addr_i;
					if (dirty[repl_addr_i]) begin
						flag_writeback_o <= 1'b1;
						cam_addr_o       <= repl_addr_i;  // old tag shows up next cycle
						cache_mem_add_o  <= {repl_addr_i, {`BW_BLOCK{1'b0}}};
						state            <= ctrl_state_pkg::FILL_WRITE_BUFFER;
					end else begin
						state <= ctrl_state_pkg::FILL_READ_BUFFER;
					end
				end
			end
			// ----------------------------------------------------------------
			ctrl_state_pkg::FILL_WRITE_BUFFER: begin
				if (buffer_write_ready_i) begin
					buffer_write_ack_o <= 1'b1;
					buffer_data_o      <= cache_mem_data_i;
					if (n_xfer == '0) begin  // first word in buffer, write may go
						wb_pending <= 1'b1;
						wb_addr    <= {cam_tag_i, {`BW_BLOCK{1'b0}}};
					end
					if (last_word) begin
						n_xfer        <= '0;
						dirty[victim] <= 1'b0;
						state         <= ctrl_state_pkg::FILL_READ_BUFFER;
					end else begin
						n_xfer          <= n_next;
						cache_mem_add_o <= {victim, n_next};
					end
				end
			end
			ctrl_state_pkg::FILL_READ_BUFFER: begin
				if (buffer_read_ready_i) begin
					buffer_read_ack_o <= 1'b1;
					cache_mem_rw_o    <= 1'b1;
					cache_mem_add_o   <= {victim, n_xfer};
					cache_mem_data_o  <= buffer_data_i;
					if (last_word) begin
						n_xfer     <= '0;
						cam_wren_o <= 1'b1;  // tag from core, line from victim
						cam_addr_o <= victim;
						state      <= ctrl_state_pkg::FILL_NORMAL;
					end else begin
						n_xfer <= n_next;
					end
				end
			end
			ctrl_state_pkg::FILL_NO_SWAP_READ: begin
				if (buffer_read_ready_i) begin
					buffer_read_ack_o <= 1'b1;
					core_data_o       <= buffer_data_i;
					core_done_o       <= 1'b1;
					state             <= ctrl_state_pkg::FILL_NORMAL;
				end
			end
			default: state <= ctrl_state_pkg::FILL_NORMAL;
			endcase

			// dirty block write request, never in the same cycle as a fill request
			if (wb_pending && mem_ready_i) begin
				wb_pending      <= 1'b0;
				mem_req_o       <= 1'b1;
				mem_req_block_o <= 1'b1;
				mem_rw_o        <= 1'b1;
				mem_addr_o      <= wb_addr;
			end
		end
	end

endmodule

// File: source/mem_port_arbiter.sv
module mem_port_arbiter (
	input  logic                       clock_i,
	input  logic                       resetn_i,
	input  logic                       load_req_i,
	input  logic                       seq_idle_i,
	input  logic                       seq_mem_req_i,
	input  logic                       seq_mem_req_block_i,
	input  logic                       seq_mem_rw_i,
	input  cache_geom_pkg::word_addr_t seq_mem_addr_i,
	input  logic                       seq_buffer_read_ack_i,
	input  logic                       seq_core_done_i,
	input  logic                       ld_mem_req_i,
	input  cache_geom_pkg::word_addr_t ld_mem_addr_i,
	input  logic                       ld_buffer_read_ack_i,
	output logic                       load_grant_o,
	output logic                       mem_req_o,
	output logic                       mem_req_block_o,
	output logic                       mem_rw_o,
	output cache_geom_pkg::word_addr_t mem_addr_o,
	output logic                       buffer_read_ack_o,
	output logic                       core_done_o
);

	// grant taken only between sequencer jobs, held for the whole load
	always_ff @(posedge clock_i) begin
		if (!resetn_i)
			load_grant_o <= 1'b0;
		else if (!load_req_i)
			load_grant_o <= 1'b0;
		else if (seq_idle_i)
			load_grant_o <= 1'b1;
	end

	// ------------------------------------------------------------------------
	// command and buffer mux
	// ------------------------------------------------------------------------
	assign mem_req_o         = load_grant_o ? ld_mem_req_i : seq_mem_req_i;
	assign mem_req_block_o   = load_grant_o ? ld_mem_req_i : seq_mem_req_block_i;  // loader reads blocks
	assign mem_rw_o          = !load_grant_o && seq_mem_rw_i;
	assign mem_addr_o        = load_grant_o ? ld_mem_addr_i : seq_mem_addr_i;
	assign buffer_read_ack_o = load_grant_o ? ld_buffer_read_ack_i : seq_buffer_read_ack_i;

	assign core_done_o = seq_core_done_i && !load_grant_o;  // core stalls during a load

endmodule

// File: tb/lease_cache_properties.sv
module lease_cache_properties (
	input logic clock_i,
	input logic resetn_i,
	input logic mem_ready_i,
	input logic mem_req_i,
	input logic buffer_read_ready_i,
	input logic buffer_read_ack_i,
	input logic buffer_write_ready_i,
	input logic buffer_write_ack_i,
	input logic cam_wren_i
);

	int fail_count = 0;

	// ------------------------------------------------------------------------
	// memory command strobe
	// ------------------------------------------------------------------------
	mem_req_after_ready: assert property (@(posedge clock_i) disable iff (!resetn_i)
		mem_req_i |-> $past(mem_ready_i))
		else begin
			$error("memory request issued while the memory was not ready");
			fail_count++;
		end

	mem_req_single: assert property (@(posedge clock_i) disable iff (!resetn_i)
		mem_req_i |=> !mem_req_i)
		else begin
			$error("memory request held longer than one cycle");
			fail_count++;
		end

	// buffer acks only against a ready word or slot
	read_ack_after_ready: assert property (@(posedge clock_i) disable iff (!resetn_i)
		buffer_read_ack_i |-> $past(buffer_read_ready_i))
		else begin
			$error("buffer read acknowledged without a ready word");
			fail_count++;
		end

	write_ack_after_ready: assert property (@(posedge clock_i) disable iff (!resetn_i)
		buffer_write_ack_i |-> $past(buffer_write_ready_i))
		else begin
			$error("buffer write acknowledged without a free slot");
			fail_count++;
		end

	cam_write_single: assert property (@(posedge clock_i) disable iff (!resetn_i)
		cam_wren_i |=> !cam_wren_i)  // one tag write per fill
		else begin
			$error("tag memory write held longer than one cycle");
			fail_count++;
		end

endmodule

bind lease_cache_controller lease_cache_properties props0 (
	.clock_i              (clock_i),
	.resetn_i             (resetn_i),
	.mem_ready_i          (mem_ready_i),
	.mem_req_i            (mem_req_o),
	.buffer_read_ready_i  (buffer_read_ready_i),
	.buffer_read_ack_i    (buffer_read_ack_o),
	.buffer_write_ready_i (buffer_write_ready_i),
	.buffer_write_ack_i   (buffer_write_ack_o),
	.cam_wren_i           (cam_wren_o)
);

// File: tb/lease_cases.txt
# op tag word data line hit swap victim wb exp, all hex (op 0 load, 1 store, 2 phase change)
# exp is the fill block address, bypass load word or table section address
0 00012 3 00000000 2 1 0 0 0 00000000
1 00012 5 deadbeef 2 1 0 0 0 00000000
1 00a40 f 12345678 7 1 0 0 0 00000000
0 00333 4 00000000 0 0 1 9 0 00003330
0 00444 1 00000000 0 0 1 2 1 00004440
1 00555 8 a5a5a5a5 0 0 1 3 0 00005550
0 00666 0 00000000 0 0 1 3 1 00006660
0 00777 6 00000000 0 0 0 0 0 00007776
1 00888 a 0badf00d 0 0 0 0 0 00000000
2 00a40 1 00000002 7 1 0 0 0 007f0020
0 00333 4 00000000 9 1 0 0 0 00000000
2 00333 2 00000005 9 1 0 0 0 007f0050
0 00999 c 00000000 0 0 1 7 1 00009990

// File: tb/tb_lease_cache.sv
module tb_lease_cache;

	logic        clock_i = 1'b0;
	logic        resetn_i;
	logic        enable_i;
	logic [31:0] phase_i;
	logic        core_req_i;
	logic        core_rw_i;
	logic [19:0] core_tag_i;
	logic [3:0]  core_word_i;
	logic [31:0] core_data_i;
	logic        core_done_o;
	logic        core_hit_o;
	logic [31:0] core_data_o;
	logic        cam_hit_i;
	logic [19:0] cam_tag_i;
	logic [3:0]  cam_addr_i;
	logic        cam_wren_o;
	logic [3:0]  cam_addr_o;
	logic [31:0] cache_mem_data_i;
	logic [7:0]  cache_mem_add_o;
	logic        cache_mem_rw_o;
	logic [31:0] cache_mem_data_o;
	logic        buffer_read_ready_i;
	logic [31:0] buffer_data_i;
	logic        buffer_read_ack_o;
	logic        buffer_write_ready_i;
	logic [31:0] buffer_data_o;
	logic        buffer_write_ack_o;
	logic        mem_ready_i;
	logic        mem_req_o;
	logic        mem_req_block_o;
	logic        mem_rw_o;
	logic [23:0] mem_addr_o;
	logic        repl_done_i;
	logic [3:0]  repl_addr_i;
	logic        repl_swap_i;
	logic        policy_hit_o;
	logic        policy_miss_o;
	logic        llt_wren_o;
	logic [3:0]  llt_addr_o;
	logic [31:0] llt_data_o;
	logic        flag_writeback_o;
	logic        flag_swap_o;

	int          cycles = 0;
	int          limit;
	logic [31:0] lcg_state = 32'd88;
	logic [25:0] req_q[$];         // {rw, block, addr} as seen on the port
	logic [23:0] rd_base = '0;     // block or word being read into the buffer
	int          rd_k = 0;
	int          rd_left = 0;
	logic [19:0] cam_tags[16];     // tag memory model

	// case table
	logic [1:0]  op_q[$];          // 0 load, 1 store, 2 phase change
	logic [19:0] tag_q[$];
	logic [3:0]  word_q[$];
	logic [31:0] data_q[$];
	logic [3:0]  line_q[$];
	logic        hit_q[$];
	logic        swap_q[$];
	logic [3:0]  victim_q[$];
	logic        wb_exp_q[$];
	logic [31:0] exp_q[$];

	always #2 clock_i = ~clock_i;

	lease_cache_controller dut0 (.*);

	// ------------------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------------------
	function automatic logic draw_ready();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[18:16] != 3'd0;  // low about one cycle in eight
	endfunction

	// cache memory contents, unique per line and word
	function automatic logic [31:0] line_word(input logic [7:0] addr);
		return {16'hCA00, addr, ~addr};
	endfunction

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "stopped at first failure");
	endtask

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp)
			stop_run($sformatf("error %s: got %h, expected %h", name, got, exp));
	endtask

	task automatic expect_request(input logic rw, input logic block, input logic [23:0] addr);
		logic [25:0] r;
		if (req_q.size() == 0)
			stop_run("an expected memory request was never issued");
		r = req_q.pop_front();
		check_value("mem_rw_o", r[25], rw);
		check_value("mem_req_block_o", r[24], block);
		check_value("mem_addr_o", r[23:0], addr);
	endtask

	// one clock, then memory and buffer respond
	task automatic step();
		@(posedge clock_i);
		#1;
		cycles++;
		if (cycles > limit)
			stop_run($sformatf("timeout, the run is still busy after %0d cycles", cycles));
		if (dut0.props0.fail_count != 0)
			stop_run("a strobe rule assertion failed");
		if (buffer_read_ack_o) begin  // word consumed at the last edge
			if (rd_left == 0)
				stop_run("buffer read acknowledged while no word was available");
			rd_k++;
			rd_left--;
		end
		if (mem_req_o) begin
			req_q.push_back({mem_rw_o, mem_req_block_o, mem_addr_o});
			if (!mem_rw_o) begin
				rd_base = mem_addr_o;
				rd_k    = 0;
				rd_left = mem_req_block_o ? 16 : 1;
			end
		end
		mem_ready_i          = draw_ready();
		buffer_write_ready_i = draw_ready();
		buffer_read_ready_i  = (rd_left > 0) && draw_ready();
		buffer_data_i        = {8'h00, rd_base} + rd_k;  // word k of a block is addr + k
		cache_mem_data_i     = $isunknown(cache_mem_add_o) ? '0 : line_word(cache_mem_add_o);
	endtask

	task automatic drive_core(input int i);
		core_rw_i   = op_q[i][0];
		core_tag_i  = tag_q[i];
		core_word_i = word_q[i];
		core_data_i = data_q[i];
	endtask

	// ------------------------------------------------------------------------
	// case types
	// ------------------------------------------------------------------------
	task automatic hit_access(input int i);
		drive_core(i);
		cam_hit_i  = 1'b1;
		cam_addr_i = line_q[i];
		core_req_i = 1'b1;
		step();
		check_value("core_hit_o", core_hit_o, hit_q[i]);
		core_req_i = 1'b0;
		check_value("core_done_o", core_done_o, 1);
		check_value("policy_hit_o", policy_hit_o, 1);
		check_value("cache_mem_add_o", cache_mem_add_o, {line_q[i], word_q[i]});
		check_value("cache_mem_rw_o", cache_mem_rw_o, op_q[i][0]);
		if (op_q[i][0])
			check_value("cache_mem_data_o", cache_mem_data_o, data_q[i]);
		cam_tags[line_q[i]] = tag_q[i];
	endtask

	task automatic fill_miss(input int i);
		logic [3:0]  v = victim_q[i];
		logic [19:0] old_tag = cam_tags[victim_q[i]];
		int          n_req = wb_exp_q[i] ? 2 : 1;
		int          n_wr = 0;
		int          n_fill = 0;
		logic        wb_seen = 1'b0;
		logic        cam_seen = 1'b0;
		logic        done = 1'b0;
		drive_core(i);
		cam_hit_i   = 1'b0;
		cam_tag_i   = old_tag;  // tag memory shows the victim's tag
		repl_done_i = 1'b1;
		repl_addr_i = v;
		repl_swap_i = 1'b1;
		core_req_i  = 1'b1;
		step();
		check_value("core_hit_o", core_hit_o, hit_q[i]);
		core_req_i = 1'b0;
		check_value("policy_miss_o", policy_miss_o, 1);
		while (!done || req_q.size() < n_req) begin
			step();
			if (flag_writeback_o)
				wb_seen = 1'b1;
			if (buffer_write_ack_o) begin
				check_value("buffer_data_o", buffer_data_o, line_word({v, 4'(n_wr)}));
				n_wr++;
			end
			if (core_done_o) begin  // replayed as a hit
				if (!cam_seen)
					stop_run("core_done_o came before the tag write of the fill");
				check_value("cache_mem_add_o", cache_mem_add_o, {v, word_q[i]});
				check_value("cache_mem_rw_o", cache_mem_rw_o, op_q[i][0]);
				done = 1'b1;
			end else if (cache_mem_rw_o) begin
				check_value("cache_mem_add_o", cache_mem_add_o, {v, 4'(n_fill)});
				check_value("cache_mem_data_o", cache_mem_data_o, exp_q[i] + n_fill);
				n_fill++;
			end
			if (cam_wren_o) begin  // comes with the last fill word
				check_value("fill word count", n_fill, 16);
				check_value("cam_addr_o", cam_addr_o, v);
				cam_hit_i   = 1'b1;  // new tag now in the CAM
				cam_addr_i  = v;
				cam_tags[v] = tag_q[i];
				cam_seen    = 1'b1;
			end
		end
		repl_done_i = 1'b0;
		check_value("flag_writeback_o", wb_seen, wb_exp_q[i]);
		check_value("writeback word count", n_wr, wb_exp_q[i] ? 16 : 0);
		check_value("flag_swap_o", flag_swap_o, swap_q[i]);
		expect_request(1'b0, 1'b1, exp_q[i][23:0]);
		if (wb_exp_q[i])
			expect_request(1'b1, 1'b1, {old_tag, 4'h0});
	endtask

	task automatic bypass_miss(input int i);
		int   n_wr = 0;
		logic done = 1'b0;
		drive_core(i);
		cam_hit_i   = 1'b0;
		repl_swap_i = 1'b0;  // policy declines the block
		core_req_i  = 1'b1;
		step();
		check_value("core_hit_o", core_hit_o, hit_q[i]);
		core_req_i = 1'b0;
		check_value("policy_miss_o", policy_miss_o, 1);
		while (!done) begin
			step();
			if (buffer_write_ack_o) begin
				check_value("buffer_data_o", buffer_data_o, data_q[i]);
				n_wr++;
			end
			done = core_done_o;
		end
		if (op_q[i][0])
			check_value("buffer write count", n_wr, 1);
		else
			check_value("core_data_o", core_data_o, exp_q[i]);
		check_value("flag_swap_o", flag_swap_o, swap_q[i]);
		expect_request(op_q[i][0], 1'b0, {tag_q[i], word_q[i]});
	endtask

	task automatic phase_reload(input int i);
		int   k = 0;
		logic asked = 1'b0;
		logic done = 1'b0;
		drive_core(i);
		cam_hit_i  = 1'b1;
		cam_addr_i = line_q[i];
		phase_i    = {1'b1, 23'd0, data_q[i][7:0]};
		while (!done) begin
			core_req_i = !asked && (req_q.size() > 0);  // ask once the table read is out
			asked      = asked || core_req_i;
			step();
			if (llt_wren_o) begin
				check_value("llt_addr_o", llt_addr_o, k);
				check_value("llt_data_o", llt_data_o, exp_q[i] + k);
				k++;
			end
			if (core_done_o) begin
				check_value("table word count", k, 16);
				check_value("policy_hit_o", policy_hit_o, 1);
				check_value("cache_mem_add_o", cache_mem_add_o, {line_q[i], word_q[i]});
				done = 1'b1;
			end
		end
		core_req_i = 1'b0;
		expect_request(1'b0, 1'b1, exp_q[i][23:0]);
	endtask

	// ------------------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------------------
	initial begin
		int          fd;
		string       text;
		logic [31:0] f[10];

		resetn_i             = 1'b0;
		enable_i             = 1'b1;
		phase_i              = '0;  // bit 31 low, no phase yet
		core_req_i           = 1'b0;
		core_rw_i            = 1'b0;
		core_tag_i           = '0;
		core_word_i          = '0;
		core_data_i          = '0;
		cam_hit_i            = 1'b0;
		cam_tag_i            = '0;
		cam_addr_i           = '0;
		cache_mem_data_i     = '0;
		buffer_read_ready_i  = 1'b0;
		buffer_data_i        = '0;
		buffer_write_ready_i = 1'b0;
		mem_ready_i          = 1'b0;
		repl_done_i          = 1'b0;
		repl_addr_i          = '0;
		repl_swap_i          = 1'b0;
		foreach (cam_tags[n])
			cam_tags[n] = '0;

		fd = $fopen("tb/lease_cases.txt", "r");
		if (fd == 0)
			stop_run("cannot open tb/lease_cases.txt");
		while ($fgets(text, fd) != 0) begin
			if (text.len() > 1 && text[0] != "#") begin
				if ($sscanf(text, "%h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2], f[3],
						f[4], f[5], f[6], f[7], f[8], f[9]) == 10) begin
					op_q.push_back(f[0][1:0]);
					tag_q.push_back(f[1][19:0]);
					word_q.push_back(f[2][3:0]);
					data_q.push_back(f[3]);
					line_q.push_back(f[4][3:0]);
					hit_q.push_back(f[5][0]);
					swap_q.push_back(f[6][0]);
					victim_q.push_back(f[7][3:0]);
					wb_exp_q.push_back(f[8][0]);
					exp_q.push_back(f[9]);
				end
			end
		end
		$fclose(fd);
		if (op_q.size() == 0)
			stop_run("no cases found in tb/lease_cases.txt");
		limit = 200 * op_q.size();

		repeat (10) @(posedge clock_i);
		#1;
		resetn_i = 1'b1;
		check_value("core_done_o", core_done_o, 0);
		check_value("mem_req_o", mem_req_o, 0);
		check_value("cam_wren_o", cam_wren_o, 0);
		check_value("llt_wren_o", llt_wren_o, 0);

		for (int i = 0; i < op_q.size(); i++) begin
			if (op_q[i] == 2'd2)
				phase_reload(i);
			else if (hit_q[i])
				hit_access(i);
			else if (swap_q[i])
				fill_miss(i);
			else
				bypass_miss(i);
			check_value("extra memory requests", req_q.size(), 0);
		end

		$display("Simulation PASSED");
		$finish;
	end

endmodule
